/* src/routerPkg.sv */
package routerPkg;

  // input directions, in the order the arbiter rotates through them.
  localparam int numPorts = 5;
  localparam int portLocal = 0;
  localparam int portNorth = 1;
  localparam int portEast = 2;
  localparam int portWest = 3;
  localparam int portSouth = 4;

  localparam int payloadWidth = 16;
  localparam int lengthWidth = 12; // packet length in flits, head included.

  localparam int fifoDepth = 8;
  localparam int ptrWidth = $clog2(fifoDepth);
  localparam int countWidth = $clog2(fifoDepth + 1);
  localparam logic [countWidth-1:0] fullCount = countWidth'(fifoDepth);

  typedef enum logic [2:0] {
    headFlit = 3'd1,
    bodyFlit = 3'd2,
    tailFlit = 3'd3
  } flitKindT;

  // a head flit keeps the packet length in the low payload bits.
  typedef struct packed {
    flitKindT kind;
    logic [payloadWidth-1:0] payload;
  } flitT;

endpackage

/* src/inputChannel.sv */
`timescale 1ns/1ns

module inputChannel (
  input  logic            clk,
  input  logic            rst,
  input  logic            inReq,
  output logic            inAck,
  input  routerPkg::flitT inFlit,
  input  logic            pop,
  output logic            notEmpty,
  output routerPkg::flitT headFlit
);

  routerPkg::flitT mem [routerPkg::fifoDepth];
  logic [routerPkg::ptrWidth-1:0] wrPtr;
  logic [routerPkg::ptrWidth-1:0] rdPtr;
  logic [routerPkg::countWidth-1:0] count;
  logic full;
  logic capture;

  assign full = (count == routerPkg::fullCount);
  assign notEmpty = (count != '0);
  assign headFlit = mem[rdPtr];

  // a new request is taken only with ack low and room in the buffer.
  assign capture = inReq && !inAck && !full;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      inAck <= 1'b0;
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (capture)
      begin
        inAck <= 1'b1;
        wrPtr <= wrPtr + 1'b1;
      end
      else if (!inReq)
      begin
        inAck <= 1'b0; // sender has released its request.
      end

      if (pop)
      begin
        rdPtr <= rdPtr + 1'b1;
      end

      case ({capture, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (capture)
    begin
      mem[wrPtr] <= inFlit;
    end
  end

  // the output side must only take flits that are already buffered.
  assert property (@(posedge clk) disable iff (rst) pop |-> notEmpty)
    else $error("inputChannel: pop while empty");

  // an ack edge always stands for a flit that found room in the buffer.
  assert property (@(posedge clk) disable iff (rst) $rose(inAck) |-> !$past(full))
    else $error("inputChannel: flit acked while full");

endmodule

/* src/packetTimer.sv */
`timescale 1ns/1ns

module packetTimer (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              run,
  input  logic                              pop,
  input  routerPkg::flitKindT               kind,
  input  logic [routerPkg::lengthWidth-1:0] length,
  output logic                              done
);

  logic [routerPkg::lengthWidth-1:0] count;
  logic [routerPkg::lengthWidth-1:0] lenReg;
  logic headPop;

  assign headPop = pop && (kind == routerPkg::headFlit);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
      lenReg <= '0;
    end
    else
    begin
      if (headPop)
      begin
        lenReg <= length;
      end

      if (!run)
      begin
        count <= '0; // no grant, so nothing to count.
      end
      else if (headPop)
      begin
        count <= {{(routerPkg::lengthWidth-1){1'b0}}, 1'b1}; // head starts a new packet.
      end
      else if (pop)
      begin
        count <= count + 1'b1;
      end
    end
  end

  assign done = (count != '0) && (count == lenReg);

  // the arbiter must drop the grant before more flits than the packet holds are taken.
  assert property (@(posedge clk) disable iff (rst) (lenReg != '0) |-> (count <= lenReg))
    else $error("packetTimer: count %0d beyond length %0d", count, lenReg);

endmodule

/* src/outputArbiter.sv */
`timescale 1ns/1ns

module outputArbiter (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [routerPkg::numPorts-1:0] notEmpty,
  input  logic [routerPkg::numPorts-1:0] pop,
  input  routerPkg::flitT                headFlit [routerPkg::numPorts],
  output logic [routerPkg::numPorts-1:0] grant
);

  // bit 0 is idle, bit i+1 grants input i.
  logic [routerPkg::numPorts:0] state;
  logic [routerPkg::numPorts:0] nextState;
  logic [routerPkg::numPorts-1:0] done;

  // one-hot state of the first ready input among span inputs, starting at start.
  function automatic logic [routerPkg::numPorts:0] firstReady(
    input logic [routerPkg::numPorts-1:0] ready,
    input int start,
    input int span
  );
    logic [routerPkg::numPorts:0] pick;
    int idx;
    pick = '0;
    pick[0] = 1'b1;
    // walk backwards so the earliest candidate is written last.
    for (int k = routerPkg::numPorts - 1; k >= 0; k--)
    begin
      idx = (start + k) % routerPkg::numPorts;
      if (k < span && ready[idx])
      begin
        pick = '0;
        pick[idx + 1] = 1'b1;
      end
    end
    return pick;
  endfunction

  always_comb
  begin
    nextState = firstReady(notEmpty, routerPkg::portLocal, routerPkg::numPorts);
    for (int x = 0; x < routerPkg::numPorts; x++)
    begin
      if (state[x + 1])
      begin
        if (notEmpty[x] && !done[x])
        begin
          nextState = state; // keep the packet going.
        end
        else
        begin
          nextState = firstReady(notEmpty, x + 1, routerPkg::numPorts - 1);
        end
      end
    end
    if (!$onehot(state))
    begin
      nextState = '0;
      nextState[0] = 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= {{routerPkg::numPorts{1'b0}}, 1'b1};
    end
    else
    begin
      state <= nextState;
    end
  end

  assign grant = state[routerPkg::numPorts:1];

  // each timer runs only while its own input holds the grant.
  for (genvar i = 0; i < routerPkg::numPorts; i++)
  begin : timerGen
    packetTimer portTimer (
      .clk    (clk),
      .rst    (rst),
      .run    (state[i + 1]),
      .pop    (pop[i]),
      .kind   (headFlit[i].kind),
      .length (headFlit[i].payload[routerPkg::lengthWidth-1:0]),
      .done   (done[i])
    );
  end

  assert property (@(posedge clk) disable iff (rst) $onehot(state))
    else $error("outputArbiter: state not one-hot");

  // leaving idle always lands on an input that had a flit waiting.
  assert property (@(posedge clk) disable iff (rst)
    $fell(state[0]) |-> |(grant & $past(notEmpty)))
    else $error("outputArbiter: grant to an empty input");

endmodule

/* src/outputChannel.sv */
`timescale 1ns/1ns

module outputChannel (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [routerPkg::numPorts-1:0] grant,
  input  logic [routerPkg::numPorts-1:0] notEmpty,
  input  routerPkg::flitT                headFlit [routerPkg::numPorts],
  output logic [routerPkg::numPorts-1:0] pop,
  output logic                           outReq,
  input  logic                           outAck,
  output routerPkg::flitT                outFlit
);

  typedef enum logic [1:0] {
    idle,
    waitAckHigh,
    waitAckLow
  } chanStateT;

  chanStateT state;
  routerPkg::flitT selFlit;
  logic [routerPkg::numPorts-1:0] ready;

  assign ready = grant & notEmpty;
  assign pop = (state == idle) ? ready : '0; // one flit per handshake.
  assign outReq = (state == waitAckHigh);

  always_comb
  begin
    selFlit = '0;
    for (int i = 0; i < routerPkg::numPorts; i++)
    begin
      if (grant[i])
      begin
        selFlit = headFlit[i];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= idle;
    end
    else
    begin
      case (state)
        idle:
        begin
          if (|pop)
          begin
            state <= waitAckHigh;
          end
        end
        waitAckHigh:
        begin
          if (outAck)
          begin
            state <= waitAckLow;
          end
        end
        waitAckLow:
        begin
          if (!outAck)
          begin
            state <= idle; // receiver has closed the handshake.
          end
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (|pop)
    begin
      outFlit <= selFlit;
    end
  end

  // the arbiter never grants two inputs at once.
  assert property (@(posedge clk) disable iff (rst) $onehot0(pop))
    else $error("outputChannel: pop not one-hot");

  assert property (@(posedge clk) disable iff (rst) outReq && $past(outReq) |-> $stable(outFlit))
    else $error("outputChannel: outFlit changed during request");

endmodule

/* src/routerPort.sv */
`timescale 1ns/1ns

module routerPort (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [routerPkg::numPorts-1:0] inReq,
  output logic [routerPkg::numPorts-1:0] inAck,
  input  routerPkg::flitT                inFlit [routerPkg::numPorts],
  output logic                           outReq,
  input  logic                           outAck,
  output routerPkg::flitT                outFlit
);

  logic [routerPkg::numPorts-1:0] notEmpty;
  logic [routerPkg::numPorts-1:0] pop;
  logic [routerPkg::numPorts-1:0] grant;
  routerPkg::flitT headFlit [routerPkg::numPorts];

  inputChannel inLocal (
    .clk(clk), .rst(rst),
    .inReq(inReq[routerPkg::portLocal]), .inAck(inAck[routerPkg::portLocal]),
    .inFlit(inFlit[routerPkg::portLocal]), .pop(pop[routerPkg::portLocal]),
    .notEmpty(notEmpty[routerPkg::portLocal]), .headFlit(headFlit[routerPkg::portLocal])
  );

  inputChannel inNorth (
    .clk(clk), .rst(rst),
    .inReq(inReq[routerPkg::portNorth]), .inAck(inAck[routerPkg::portNorth]),
    .inFlit(inFlit[routerPkg::portNorth]), .pop(pop[routerPkg::portNorth]),
    .notEmpty(notEmpty[routerPkg::portNorth]), .headFlit(headFlit[routerPkg::portNorth])
  );

  inputChannel inEast (
    .clk(clk), .rst(rst),
    .inReq(inReq[routerPkg::portEast]), .inAck(inAck[routerPkg::portEast]),
    .inFlit(inFlit[routerPkg::portEast]), .pop(pop[routerPkg::portEast]),
    .notEmpty(notEmpty[routerPkg::portEast]), .headFlit(headFlit[routerPkg::portEast])
  );

  inputChannel inWest (
    .clk(clk), .rst(rst),
    .inReq(inReq[routerPkg::portWest]), .inAck(inAck[routerPkg::portWest]),
    .inFlit(inFlit[routerPkg::portWest]), .pop(pop[routerPkg::portWest]),
    .notEmpty(notEmpty[routerPkg::portWest]), .headFlit(headFlit[routerPkg::portWest])
  );

  inputChannel inSouth (
    .clk(clk), .rst(rst),
    .inReq(inReq[routerPkg::portSouth]), .inAck(inAck[routerPkg::portSouth]),
    .inFlit(inFlit[routerPkg::portSouth]), .pop(pop[routerPkg::portSouth]),
    .notEmpty(notEmpty[routerPkg::portSouth]), .headFlit(headFlit[routerPkg::portSouth])
  );

  // the arbiter sees the same pops as the inputs to pace its timers.
  outputArbiter arbiter (
    .clk      (clk),
    .rst      (rst),
    .notEmpty (notEmpty),
    .pop      (pop),
    .headFlit (headFlit),
    .grant    (grant)
  );

  outputChannel outChan (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .notEmpty (notEmpty),
    .headFlit (headFlit),
    .pop      (pop),
    .outReq   (outReq),
    .outAck   (outAck),
    .outFlit  (outFlit)
  );

endmodule

/* sim/routerPortTb.sv */
`timescale 1ns/1ns

module routerPortTb;

  localparam int totalFlits = 58;
  localparam int watchdogCycles = totalFlits * 40 + 500;

  logic clk;
  logic rst;
  logic [routerPkg::numPorts-1:0] inReq;
  logic [routerPkg::numPorts-1:0] inAck;
  routerPkg::flitT inFlit [routerPkg::numPorts];
  logic outReq;
  logic outAck;
  routerPkg::flitT outFlit;

  routerPkg::flitT txQ [routerPkg::numPorts][$]; // flits the senders still have to offer.
  routerPkg::flitT parkQ [routerPkg::numPorts][$];
  routerPkg::flitT expQ [routerPkg::numPorts][$]; // model copy of every flit sent.
  int seqNo [routerPkg::numPorts];
  int ackCount [routerPkg::numPorts];
  int baseAck [routerPkg::numPorts];
  int rxOrder [$];
  int rxTotal;
  int lastSrc;
  int remain;
  bit strict;
  bit stall;
  int errorCount;
  int errBase;
  int passCount;
  int failCount;
  routerPkg::flitT held;

  routerPort uut (
    .clk(clk), .rst(rst), .inReq(inReq), .inAck(inAck), .inFlit(inFlit),
    .outReq(outReq), .outAck(outAck), .outFlit(outFlit)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // head payload is {source, 0, length}, the others carry {source, sequence number}.
  function automatic routerPkg::flitT makeFlit(input int src, input int idx, input int len);
    routerPkg::flitT f;
    f.kind = (idx == len - 1) ? routerPkg::tailFlit : routerPkg::bodyFlit;
    f.payload = {src[2:0], 13'(seqNo[src])};
    if (idx == 0)
    begin
      f.kind = routerPkg::headFlit;
      f.payload = {src[2:0], 1'b0, 12'(len)};
    end
    return f;
  endfunction

  function automatic void queuePacket(input int src, input int len, input int sendNow);
    routerPkg::flitT f;
    for (int idx = 0; idx < len; idx++)
    begin
      f = makeFlit(src, idx, len);
      seqNo[src]++;
      expQ[src].push_back(f);
      if (idx < sendNow) txQ[src].push_back(f);
      else parkQ[src].push_back(f); // held back until the test releases it.
    end
  endfunction

  function automatic void releaseParked(input int src);
    while (parkQ[src].size() != 0) txQ[src].push_back(parkQ[src].pop_front());
  endfunction

  function automatic int pendingTotal();
    int n;
    n = 0;
    for (int s = 0; s < routerPkg::numPorts; s++) n += expQ[s].size();
    return n;
  endfunction

  function automatic int filledCount();
    int n;
    n = 0;
    for (int s = 0; s < routerPkg::numPorts; s++)
      if (ackCount[s] - baseAck[s] >= routerPkg::fifoDepth) n++;
    return n;
  endfunction

  // whole packets leave in rotation, the next one from the first source after the last one.
  function automatic routerPkg::flitT refNext(input int src);
    routerPkg::flitT f;
    int pick;
    pick = src;
    if (strict)
    begin
      if (remain == 0)
      begin
        for (int k = routerPkg::numPorts; k >= 1; k--)
          if (expQ[(lastSrc + k) % routerPkg::numPorts].size() != 0)
            pick = (lastSrc + k) % routerPkg::numPorts;
        f = expQ[pick][0];
        remain = int'(f.payload[routerPkg::lengthWidth-1:0]);
        lastSrc = pick;
      end
      pick = lastSrc;
      remain--;
    end
    f = expQ[pick].pop_front();
    return f;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want)
    begin
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, want);
      errorCount++;
    end
  endtask

  task automatic beginTest(input bit strictMode, input bit stallMode);
    errBase = errorCount;
    strict = strictMode;
    stall = stallMode;
    lastSrc = routerPkg::portSouth; // so that an idle arbiter starts at Local.
    remain = 0;
    rxTotal = 0;
    rxOrder.delete();
    for (int s = 0; s < routerPkg::numPorts; s++) baseAck[s] = ackCount[s];
  endtask

  task automatic endTest(input string name);
    if (errorCount == errBase)
    begin
      $display("test %s: pass", name);
      passCount++;
    end
    else
    begin
      $display("test %s: FAIL with %0d errors", name, errorCount - errBase);
      failCount++;
    end
  endtask

  task automatic awaitFlits(input int target);
    while (rxTotal < target) @(negedge clk);
    while (outReq || outAck) @(negedge clk);
  endtask

  // one four-phase sender per direction, all stepped on the same edge.
  initial
  begin : driver
    int phase [routerPkg::numPorts];
    routerPkg::flitT f;
    inReq <= '0;
    for (int s = 0; s < routerPkg::numPorts; s++)
    begin
      inFlit[s] <= '0;
      phase[s] = 0;
    end
    forever
    begin
      @(posedge clk);
      for (int s = 0; s < routerPkg::numPorts; s++)
      begin
        case (phase[s])
          0:
          begin
            if (txQ[s].size() != 0)
            begin
              f = txQ[s].pop_front();
              inFlit[s] <= f;
              inReq[s] <= 1'b1;
              phase[s] = 1;
            end
          end
          1:
          begin
            if (inAck[s])
            begin
              inReq[s] <= 1'b0;
              ackCount[s]++;
              phase[s] = 2;
            end
          end
          default: if (!inAck[s]) phase[s] = 0;
        endcase
      end
    end
  end

  initial
  begin : responder
    int delay;
    void'($urandom(32'hcfaa_a021));
    outAck <= 1'b0;
    forever
    begin
      @(posedge clk);
      if (outReq && !stall)
      begin
        delay = $urandom % 4;
        repeat (delay) @(posedge clk);
        outAck <= 1'b1;
        do @(posedge clk); while (outReq);
        outAck <= 1'b0;
      end
    end
  end

  initial
  begin : monitor
    logic prevReq;
    int src;
    routerPkg::flitT want;
    prevReq = 1'b0;
    forever
    begin
      @(posedge clk);
      if (outReq && !prevReq)
      begin
        src = int'(outFlit.payload[15:13]);
        if (src >= routerPkg::numPorts || (strict ? pendingTotal() == 0 : expQ[src].size() == 0))
        begin
          $display("Error at %0t: flit %h from source %0d arrived with nothing pending",
            $time, outFlit, src);
          errorCount++;
        end
        else
        begin
          want = refNext(src);
          checkValue("outFlit", 32'(outFlit), 32'(want));
        end
        rxOrder.push_back(src);
        rxTotal++;
      end
      prevReq = outReq;
    end
  end

  initial
  begin : main
    int starveOrder [6];
    errorCount = 0;
    passCount = 0;
    failCount = 0;
    for (int s = 0; s < routerPkg::numPorts; s++)
    begin
      seqNo[s] = 0;
      ackCount[s] = 0;
    end
    beginTest(1'b1, 1'b0);
    rst <= 1'b1;
    repeat (10) @(posedge clk);
    rst <= 1'b0;

    @(negedge clk);
    beginTest(1'b1, 1'b0);
    repeat (12)
    begin
      @(posedge clk);
      checkValue("outReq", 32'(outReq), 32'd0);
      checkValue("inAck", 32'(inAck), 32'd0);
    end
    checkValue("flits out", rxTotal, 32'd0);
    endTest("reset state");

    @(negedge clk);
    beginTest(1'b1, 1'b0);
    queuePacket(routerPkg::portNorth, 3, 3);
    queuePacket(routerPkg::portNorth, 1, 1);
    queuePacket(routerPkg::portNorth, 5, 5);
    awaitFlits(9);
    checkValue("pending flits", pendingTotal(), 32'd0);
    endTest("single source");

    // east stops after its head, west fills the gap.
    @(negedge clk);
    beginTest(1'b0, 1'b0);
    queuePacket(routerPkg::portEast, 4, 1);
    while (ackCount[routerPkg::portEast] == baseAck[routerPkg::portEast]) @(negedge clk);
    queuePacket(routerPkg::portWest, 2, 2);
    repeat (40) @(negedge clk);
    releaseParked(routerPkg::portEast);
    awaitFlits(6);
    starveOrder = '{2, 3, 3, 2, 2, 2};
    for (int i = 0; i < 6; i++) checkValue("source order", rxOrder[i], starveOrder[i]);
    checkValue("pending flits", pendingTotal(), 32'd0);
    endTest("starved source");

    // a single-flit packet parks the channel so that every buffer can fill.
    @(negedge clk);
    beginTest(1'b1, 1'b1);
    held = makeFlit(routerPkg::portSouth, 0, 1);
    queuePacket(routerPkg::portSouth, 1, 1);
    while (!outReq) @(negedge clk);
    repeat (3) @(negedge clk);
    for (int s = 0; s < routerPkg::numPorts; s++) baseAck[s] = ackCount[s];
    queuePacket(routerPkg::portLocal, 3, 3);
    queuePacket(routerPkg::portLocal, 5, 5);
    queuePacket(routerPkg::portLocal, 2, 2); // no room for this one until the drain.
    queuePacket(routerPkg::portNorth, 4, 4);
    queuePacket(routerPkg::portNorth, 4, 4);
    queuePacket(routerPkg::portEast, 2, 2);
    queuePacket(routerPkg::portEast, 6, 6);
    queuePacket(routerPkg::portWest, 5, 5);
    queuePacket(routerPkg::portWest, 3, 3);
    queuePacket(routerPkg::portSouth, 6, 6);
    queuePacket(routerPkg::portSouth, 2, 2);
    while (filledCount() < routerPkg::numPorts) @(negedge clk);
    repeat (4) @(negedge clk);
    repeat (20)
    begin
      @(posedge clk);
      checkValue("outReq", 32'(outReq), 32'd1);
      checkValue("outFlit", 32'(outFlit), 32'(held));
      checkValue("inAck", 32'(inAck), 32'd0);
    end
    checkValue("local acks", ackCount[routerPkg::portLocal] - baseAck[routerPkg::portLocal], 8);
    @(negedge clk);
    stall = 1'b0;
    awaitFlits(43);
    checkValue("pending flits", pendingTotal(), 32'd0);
    endTest("load, rotation and back-pressure");

    $display("tests passed %0d, failed %0d, errors %0d", passCount, failCount, errorCount);
    if (failCount == 0 && errorCount == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

  initial
  begin : watchdog
    repeat (watchdogCycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, %0d flits seen in the running test",
      watchdogCycles, rxTotal);
    $display("Simulation failed");
    $finish;
  end

endmodule

/* sources.f */
src/routerPkg.sv
src/inputChannel.sv
src/packetTimer.sv
src/outputArbiter.sv
src/outputChannel.sv
src/routerPort.sv
sim/routerPortTb.sv

/* run.sh */
#!/bin/sh
# builds the router port testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module routerPortTb -f sources.f
status=0
./obj_dir/VrouterPortTb > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "Simulation failed" sim.log; then
  echo "run.sh: simulation reported a failure"
  exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
  echo "run.sh: simulation ended without a result"
  exit 1
fi
